// ==== Bender.yml ====
package:
  name: reg_subsystem

sources:
  - include_dirs:
      - .
    files:
      - regfile_pkg.sv
      - zap_register_file.sv
      - bank_map.sv
      - reg_write_port.sv
      - operand_fetch.sv
      - reg_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - reg_subsystem_assert.sv
      - reg_subsystem_checker.sv
      - tb_reg_subsystem.sv

// ==== bank_map.sv ====
`timescale 1ns/10ps

module bank_map
        import regfile_pkg::*;
(
        input  cpu_mode_t       i_mode,
        input  log_addr_t       i_log,
        output phys_addr_t      o_phys
);

// Logical registers that get banked
localparam log_addr_t LOG_R8  = log_addr_t'(8);
localparam log_addr_t LOG_R13 = log_addr_t'(13);
localparam log_addr_t LOG_R14 = log_addr_t'(14);

// First physical entry of each banked group
// The user bank sits at 0 to 15, so FIQ starts right after it
localparam phys_addr_t FIQ_BASE = phys_addr_t'(16);
localparam phys_addr_t IRQ_BASE = phys_addr_t'(23);
localparam phys_addr_t SVC_BASE = phys_addr_t'(25);
localparam phys_addr_t ABT_BASE = phys_addr_t'(27);
localparam phys_addr_t UND_BASE = phys_addr_t'(29);

// r8 to r14 are replaced as a block in FIQ mode
logic           is_fiq_reg;

// r13 and r14 are replaced in the other privileged modes
logic           is_sp_lr;

// Offset within a two-entry r13/r14 bank, 0 for r13 and 1 for r14
phys_addr_t     lr_sel;

// Position in the user bank, which every unbanked case falls back to
phys_addr_t     user_idx;

always_comb
begin
        is_fiq_reg = (i_log >= LOG_R8) && (i_log <= LOG_R14);
        is_sp_lr   = (i_log == LOG_R13) || (i_log == LOG_R14);
        lr_sel     = (i_log == LOG_R14) ? phys_addr_t'(1) : phys_addr_t'(0);
        user_idx   = phys_addr_t'(i_log);

        // USR, SYS and any unknown encoding stay on the user bank
        o_phys = user_idx;

        case (i_mode)
        MODE_FIQ:
                if (is_fiq_reg)
                        o_phys = FIQ_BASE + (user_idx - phys_addr_t'(LOG_R8));
        MODE_IRQ:
                if (is_sp_lr)
                        o_phys = IRQ_BASE + lr_sel;
        MODE_SVC:
                if (is_sp_lr)
                        o_phys = SVC_BASE + lr_sel;
        MODE_ABT:
                if (is_sp_lr)
                        o_phys = ABT_BASE + lr_sel;
        MODE_UND:
                if (is_sp_lr)
                        o_phys = UND_BASE + lr_sel;
        default:
                o_phys = user_idx;
        endcase
end

endmodule

// ==== operand_fetch.sv ====
`timescale 1ns/10ps

module operand_fetch
        import regfile_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,

        // Read request
        input  logic            i_rd_valid,
        output logic            o_rd_ready,
        input  cpu_mode_t       i_rd_mode,
        input  log_addr_t       i_rd_src_a,
        input  log_addr_t       i_rd_src_b,
        input  log_addr_t       i_rd_src_c,
        input  log_addr_t       i_rd_src_d,

        // Array read ports
        output phys_addr_t      o_rf_addr_a,
        output phys_addr_t      o_rf_addr_b,
        output phys_addr_t      o_rf_addr_c,
        output phys_addr_t      o_rf_addr_d,
        input  reg_data_t       i_rf_data_a,
        input  reg_data_t       i_rf_data_b,
        input  reg_data_t       i_rf_data_c,
        input  reg_data_t       i_rf_data_d,

        // Same-cycle write, used for the bypass
        input  logic            i_wen,
        input  phys_addr_t      i_wr_addr_a,
        input  phys_addr_t      i_wr_addr_b,
        input  reg_data_t       i_wr_data_a,
        input  reg_data_t       i_wr_data_b,

        // Operand result
        output logic            o_op_valid,
        input  logic            i_op_ready,
        output reg_data_t       o_op_a,
        output reg_data_t       o_op_b,
        output reg_data_t       o_op_c,
        output reg_data_t       o_op_d
);

// Request handshake completes on this edge
logic           accept;

// Picks the freshest value for one operand
// Port b is checked first, matching the array's write order
function automatic reg_data_t bypass(input phys_addr_t addr, input reg_data_t rf_data);
        reg_data_t      val;
        val = rf_data;
        if (i_wen && (i_wr_addr_b == addr))
                val = i_wr_data_b;
        else if (i_wen && (i_wr_addr_a == addr))
                val = i_wr_data_a;
        return val;
endfunction

// All four sources use the mode of the request
bank_map u_map_a (.i_mode(i_rd_mode), .i_log(i_rd_src_a), .o_phys(o_rf_addr_a));
bank_map u_map_b (.i_mode(i_rd_mode), .i_log(i_rd_src_b), .o_phys(o_rf_addr_b));
bank_map u_map_c (.i_mode(i_rd_mode), .i_log(i_rd_src_c), .o_phys(o_rf_addr_c));
bank_map u_map_d (.i_mode(i_rd_mode), .i_log(i_rd_src_d), .o_phys(o_rf_addr_d));

// --------------------------------------------------
// Handshake and output register
// --------------------------------------------------

// A new request fits when the slot is empty or is being drained now
assign o_rd_ready = !o_op_valid || i_op_ready;
assign accept     = i_rd_valid && o_rd_ready;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_op_valid <= 1'b0;
        end
        else if (accept)
        begin
                o_op_valid <= 1'b1;
        end
        else if (i_op_ready)
        begin
                o_op_valid <= 1'b0;
        end
end

// Operands only load on acceptance, so a stalled result holds still
always_ff @(posedge i_clk)
begin
        if (accept)
        begin
                o_op_a <= bypass(o_rf_addr_a, i_rf_data_a);
                o_op_b <= bypass(o_rf_addr_b, i_rf_data_b);
                o_op_c <= bypass(o_rf_addr_c, i_rf_data_c);
                o_op_d <= bypass(o_rf_addr_d, i_rf_data_d);
        end
end

endmodule

// ==== reg_subsystem.f ====
+incdir+.
regfile_pkg.sv
zap_register_file.sv
bank_map.sv
reg_write_port.sv
operand_fetch.sv
reg_subsystem.sv
reg_subsystem_assert.sv
reg_subsystem_checker.sv
tb_reg_subsystem.sv

// ==== reg_subsystem.sv ====
`timescale 1ns/10ps

module reg_subsystem
        import regfile_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,

        // Writeback
        input  logic            i_wb_valid,
        input  cpu_mode_t       i_wb_mode,
        input  logic            i_wb_en_a,
        input  log_addr_t       i_wb_dst_a,
        input  reg_data_t       i_wb_data_a,
        input  logic            i_wb_en_b,
        input  log_addr_t       i_wb_dst_b,
        input  reg_data_t       i_wb_data_b,

        // Read request
        input  logic            i_rd_valid,
        output logic            o_rd_ready,
        input  cpu_mode_t       i_rd_mode,
        input  log_addr_t       i_rd_src_a,
        input  log_addr_t       i_rd_src_b,
        input  log_addr_t       i_rd_src_c,
        input  log_addr_t       i_rd_src_d,

        // Operand result
        output logic            o_op_valid,
        input  logic            i_op_ready,
        output reg_data_t       o_op_a,
        output reg_data_t       o_op_b,
        output reg_data_t       o_op_c,
        output reg_data_t       o_op_d
);

// --------------------------------------------------
// Internal nets
// --------------------------------------------------

// Write side shared by the array and the bypass
logic           wen;
phys_addr_t     wr_addr_a;
phys_addr_t     wr_addr_b;
reg_data_t      wr_data_a;
reg_data_t      wr_data_b;

// Array read ports
phys_addr_t     rf_addr_a;
phys_addr_t     rf_addr_b;
phys_addr_t     rf_addr_c;
phys_addr_t     rf_addr_d;
reg_data_t      rf_data_a;
reg_data_t      rf_data_b;
reg_data_t      rf_data_c;
reg_data_t      rf_data_d;

// Turns the two writeback destinations into array writes
reg_write_port u_reg_write_port (
        .i_wb_valid  (i_wb_valid),
        .i_wb_mode   (i_wb_mode),
        .i_wb_en_a   (i_wb_en_a),
        .i_wb_dst_a  (i_wb_dst_a),
        .i_wb_data_a (i_wb_data_a),
        .i_wb_en_b   (i_wb_en_b),
        .i_wb_dst_b  (i_wb_dst_b),
        .i_wb_data_b (i_wb_data_b),
        .o_wen       (wen),
        .o_wr_addr_a (wr_addr_a),
        .o_wr_addr_b (wr_addr_b),
        .o_wr_data_a (wr_data_a),
        .o_wr_data_b (wr_data_b)
);

// Four-operand read with output register and bypass
operand_fetch u_operand_fetch (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rd_valid  (i_rd_valid),
        .o_rd_ready  (o_rd_ready),
        .i_rd_mode   (i_rd_mode),
        .i_rd_src_a  (i_rd_src_a),
        .i_rd_src_b  (i_rd_src_b),
        .i_rd_src_c  (i_rd_src_c),
        .i_rd_src_d  (i_rd_src_d),
        .o_rf_addr_a (rf_addr_a),
        .o_rf_addr_b (rf_addr_b),
        .o_rf_addr_c (rf_addr_c),
        .o_rf_addr_d (rf_addr_d),
        .i_rf_data_a (rf_data_a),
        .i_rf_data_b (rf_data_b),
        .i_rf_data_c (rf_data_c),
        .i_rf_data_d (rf_data_d),
        .i_wen       (wen),
        .i_wr_addr_a (wr_addr_a),
        .i_wr_addr_b (wr_addr_b),
        .i_wr_data_a (wr_data_a),
        .i_wr_data_b (wr_data_b),
        .o_op_valid  (o_op_valid),
        .i_op_ready  (i_op_ready),
        .o_op_a      (o_op_a),
        .o_op_b      (o_op_b),
        .o_op_c      (o_op_c),
        .o_op_d      (o_op_d)
);

// Flip-flop storage for all banked registers
zap_register_file u_zap_register_file (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wen       (wen),
        .i_wr_addr_a (wr_addr_a),
        .i_wr_addr_b (wr_addr_b),
        .i_wr_data_a (wr_data_a),
        .i_wr_data_b (wr_data_b),
        .i_rd_addr_a (rf_addr_a),
        .i_rd_addr_b (rf_addr_b),
        .i_rd_addr_c (rf_addr_c),
        .i_rd_addr_d (rf_addr_d),
        .o_rd_data_a (rf_data_a),
        .o_rd_data_b (rf_data_b),
        .o_rd_data_c (rf_data_c),
        .o_rd_data_d (rf_data_d)
);

endmodule

// ==== reg_subsystem_assert.sv ====
`timescale 1ns/10ps

module reg_subsystem_assert
        import regfile_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_op_valid,
        input  logic            i_op_ready,
        input  logic            i_rd_ready,
        input  reg_data_t       i_op_a,
        input  reg_data_t       i_op_b,
        input  reg_data_t       i_op_c,
        input  reg_data_t       i_op_d
);

// Number of property failures seen so far
int             fail_count = 0;

// --------------------------------------------------
// Handshake properties
// --------------------------------------------------

// The result slot comes out of reset empty
reset_empties_slot: assert property (@(posedge i_clk) i_reset |=> !i_op_valid)
        else
        begin
                fail_count++;
                $error("operand valid high in the cycle after reset");
        end

// A stalled result keeps its valid and all four operands
stall_holds_operands: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_op_valid && !i_op_ready) |=>
                (i_op_valid && $stable({i_op_a, i_op_b, i_op_c, i_op_d})))
        else
        begin
                fail_count++;
                $error("operands changed while the result was stalled");
        end

// An empty slot always takes a request
empty_means_ready: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_op_valid |-> i_rd_ready)
        else
        begin
                fail_count++;
                $error("read ready low while the result slot is empty");
        end

endmodule

bind reg_subsystem reg_subsystem_assert u_reg_subsystem_assert (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_op_valid (o_op_valid),
        .i_op_ready (i_op_ready),
        .i_rd_ready (o_rd_ready),
        .i_op_a     (o_op_a),
        .i_op_b     (o_op_b),
        .i_op_c     (o_op_c),
        .i_op_d     (o_op_d)
);

// ==== reg_subsystem_checker.sv ====
`timescale 1ns/10ps

module reg_subsystem_checker
        import regfile_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,

        // Request side, used to queue the expected operands
        input  logic            i_rd_valid,
        input  logic            i_rd_ready,
        input  reg_data_t       i_exp_a,
        input  reg_data_t       i_exp_b,
        input  reg_data_t       i_exp_c,
        input  reg_data_t       i_exp_d,

        // Result side of the DUT
        input  logic            i_op_valid,
        input  logic            i_op_ready,
        input  reg_data_t       i_op_a,
        input  reg_data_t       i_op_b,
        input  reg_data_t       i_op_c,
        input  reg_data_t       i_op_d,

        output int              o_error_count,
        output int              o_result_count,
        output int              o_pending
);

// One queue per operand, always the same depth
reg_data_t      exp_a_q[$];
reg_data_t      exp_b_q[$];
reg_data_t      exp_c_q[$];
reg_data_t      exp_d_q[$];

task automatic compare_operand(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp)
        begin
                $display("FAILED %s at %0t: got 0x%h expected 0x%h", name, $time, got, exp);
                o_error_count++;
        end
endtask

// --------------------------------------------------
// Sampling at mid cycle
// --------------------------------------------------

// Inputs change 1 ns after the rising edge, so the falling edge sees settled values
// and predicts both transfers of the coming rising edge
always @(negedge i_clk)
begin
        if (i_reset)
        begin
                exp_a_q.delete();
                exp_b_q.delete();
                exp_c_q.delete();
                exp_d_q.delete();
                o_error_count  = 0;
                o_result_count = 0;
        end
        else
        begin
                // Pop before push so that a stray result never matches the newest request
                if (i_op_valid && i_op_ready)
                begin
                        if (exp_a_q.size() == 0)
                        begin
                                $display("ERROR: operand result at %0t with no read outstanding",
                                         $time);
                                o_error_count++;
                        end
                        else
                        begin
                                compare_operand("o_op_a", i_op_a, exp_a_q.pop_front());
                                compare_operand("o_op_b", i_op_b, exp_b_q.pop_front());
                                compare_operand("o_op_c", i_op_c, exp_c_q.pop_front());
                                compare_operand("o_op_d", i_op_d, exp_d_q.pop_front());
                                o_result_count++;
                        end
                end
                if (i_rd_valid && i_rd_ready)
                begin
                        exp_a_q.push_back(i_exp_a);
                        exp_b_q.push_back(i_exp_b);
                        exp_c_q.push_back(i_exp_c);
                        exp_d_q.push_back(i_exp_d);
                end
        end
        o_pending = exp_a_q.size();
end

endmodule

// ==== reg_subsystem_stim.txt ====
# W mode en_a dst_a data_a en_b dst_b data_b                 (all fields hex)
# R mode src_a src_b src_c src_d exp_a exp_b exp_c exp_d     (all fields hex)
R 10 0 8 d f 00000000 00000000 00000000 00000000
R 11 8 e 3 d 00000000 00000000 00000000 00000000
R 1b d e 7 3 00000000 00000000 00000000 00000000
W 10 1 0 00000100 1 7 00000107
W 10 1 8 00000108 1 d 0000010d
W 10 1 e 0000010e 1 f 0000010f
R 1f 0 7 8 d 00000100 00000107 00000108 0000010d
R 11 0 7 e f 00000100 00000107 00000000 0000010f
W 11 1 8 00000f08 1 e 00000f0e
W 12 1 d 0000120d 0 0 00000000
W 13 0 0 00000000 1 d 0000130d
W 17 1 d 0000170d 1 e 0000170e
W 1b 1 d 00001b0d 0 0 00000000
R 10 8 d e f 00000108 0000010d 0000010e 0000010f
R 11 8 d e 7 00000f08 00000000 00000f0e 00000107
R 12 d e 8 0 0000120d 00000000 00000108 00000100
R 13 d e 0 7 0000130d 00000000 00000100 00000107
R 17 d e 8 f 0000170d 0000170e 00000108 0000010f
R 1b d e 0 7 00001b0d 00000000 00000100 00000107
W 1f 1 3 0000aaaa 1 3 0000bbbb
W 10 1 4 00004444 0 0 00000000
R 10 4 3 0 4 00004444 0000bbbb 00000100 00004444
R 11 3 4 f 0 0000bbbb 00004444 0000010f 00000100
R 13 e d 8 9 00000000 0000130d 00000108 00000000

// ==== reg_write_port.sv ====
`timescale 1ns/10ps

module reg_write_port
        import regfile_pkg::*;
(
        // Writeback request from the pipeline
        input  logic            i_wb_valid,
        input  cpu_mode_t       i_wb_mode,
        input  logic            i_wb_en_a,
        input  log_addr_t       i_wb_dst_a,
        input  reg_data_t       i_wb_data_a,
        input  logic            i_wb_en_b,
        input  log_addr_t       i_wb_dst_b,
        input  reg_data_t       i_wb_data_b,

        // Array write side, also seen by the operand bypass
        output logic            o_wen,
        output phys_addr_t      o_wr_addr_a,
        output phys_addr_t      o_wr_addr_b,
        output reg_data_t       o_wr_data_a,
        output reg_data_t       o_wr_data_b
);

// Physical targets of both destinations in the current mode
phys_addr_t     phys_a;
phys_addr_t     phys_b;

// Both destinations are translated with the writeback mode
bank_map u_map_a (
        .i_mode (i_wb_mode),
        .i_log  (i_wb_dst_a),
        .o_phys (phys_a)
);

bank_map u_map_b (
        .i_mode (i_wb_mode),
        .i_log  (i_wb_dst_b),
        .o_phys (phys_b)
);

// --------------------------------------------------
// Enable folding
// --------------------------------------------------

// The array has one enable for both ports
// When only one port is live, it is mirrored onto the other port
// so the second write hits the same register with the same value
always_comb
begin
        o_wen       = i_wb_valid && (i_wb_en_a || i_wb_en_b);
        o_wr_addr_a = phys_a;
        o_wr_data_a = i_wb_data_a;
        o_wr_addr_b = phys_b;
        o_wr_data_b = i_wb_data_b;

        if (i_wb_en_a && !i_wb_en_b)
        begin
                o_wr_addr_b = phys_a;
                o_wr_data_b = i_wb_data_a;
        end
        else if (i_wb_en_b && !i_wb_en_a)
        begin
                o_wr_addr_a = phys_b;
                o_wr_data_a = i_wb_data_b;
        end
end

endmodule

// ==== regfile_config.svh ====
`ifndef REGFILE_CONFIG_SVH
`define REGFILE_CONFIG_SVH

// --------------------------------------------------
// Register file sizing
// --------------------------------------------------

// Physical flip-flop registers, including the banked copies
// Entries 31 to 39 are held back for saved status copies
`define RF_NUM_REGS 40

// Width of one register value
`define RF_DATA_W 32

// Index widths for the physical array and the logical r0 to r15 space
`define RF_PHYS_W 6
`define RF_LOG_W 4

`endif

// ==== regfile_pkg.sv ====
`include "regfile_config.svh"

package regfile_pkg;

        // --------------------------------------------------
        // Width types
        // --------------------------------------------------

        // One register value as stored in the array
        typedef logic [`RF_DATA_W-1:0] reg_data_t;

        // Index into the 40 entry physical array
        typedef logic [`RF_PHYS_W-1:0] phys_addr_t;

        // Logical register number as seen by an instruction
        typedef logic [`RF_LOG_W-1:0] log_addr_t;

        // Processor mode, using the CPSR mode field encodings
        typedef enum logic [4:0] {
                MODE_USR = 5'b10000,
                MODE_FIQ = 5'b10001,
                MODE_IRQ = 5'b10010,
                MODE_SVC = 5'b10011,
                MODE_ABT = 5'b10111,
                MODE_UND = 5'b11011,
                MODE_SYS = 5'b11111
        } cpu_mode_t;

endpackage

// ==== tb_reg_subsystem.sv ====
`timescale 1ns/10ps

module tb_reg_subsystem
        import regfile_pkg::*;
();

// Cycle limits for the request wait and the final drain
localparam int RD_TIMEOUT    = 64;
localparam int DRAIN_TIMEOUT = 128;

// --------------------------------------------------
// DUT signals
// --------------------------------------------------

logic           i_clk;
logic           i_reset;
logic           i_wb_valid;
cpu_mode_t      i_wb_mode;
logic           i_wb_en_a;
log_addr_t      i_wb_dst_a;
reg_data_t      i_wb_data_a;
logic           i_wb_en_b;
log_addr_t      i_wb_dst_b;
reg_data_t      i_wb_data_b;
logic           i_rd_valid;
logic           o_rd_ready;
cpu_mode_t      i_rd_mode;
log_addr_t      i_rd_src_a;
log_addr_t      i_rd_src_b;
log_addr_t      i_rd_src_c;
log_addr_t      i_rd_src_d;
logic           o_op_valid;
logic           i_op_ready;
reg_data_t      o_op_a;
reg_data_t      o_op_b;
reg_data_t      o_op_c;
reg_data_t      o_op_d;

// Expected operands shown to the checker alongside each read request
reg_data_t      exp_a;
reg_data_t      exp_b;
reg_data_t      exp_c;
reg_data_t      exp_d;

// Counts kept by the checker
int             check_errors;
int             result_count;
int             pending;

// Property failures counted inside the bound assertion module
int             assert_errors;

// Timeouts and stimulus file problems
int             run_errors;
int             reads_sent;

// A write is on the bus and has not yet passed a rising edge
logic           wr_pending;
logic           aborted;

reg_subsystem i_reg_subsystem (.*);

reg_subsystem_checker u_checker (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rd_valid     (i_rd_valid),
        .i_rd_ready     (o_rd_ready),
        .i_exp_a        (exp_a),
        .i_exp_b        (exp_b),
        .i_exp_c        (exp_c),
        .i_exp_d        (exp_d),
        .i_op_valid     (o_op_valid),
        .i_op_ready     (i_op_ready),
        .i_op_a         (o_op_a),
        .i_op_b         (o_op_b),
        .i_op_c         (o_op_c),
        .i_op_d         (o_op_d),
        .o_error_count  (check_errors),
        .o_result_count (result_count),
        .o_pending      (pending)
);

// --------------------------------------------------
// Clock and random back-pressure
// --------------------------------------------------

initial
begin
        i_clk = 1'b0;
        forever
                #2 i_clk = ~i_clk;
end

// The consumer takes a result in about three cycles out of four
initial
begin : op_ready_gen
        int unsigned    seed;
        seed       = 32'h8b3d;
        void'($urandom(seed));
        i_op_ready = 1'b0;
        forever
        begin
                @(posedge i_clk);
                #1;
                i_op_ready = ($urandom % 4) != 0;
        end
end

// --------------------------------------------------
// Stimulus tasks
// --------------------------------------------------

// Drops the write after it has been sampled by one rising edge
task automatic retire_write();
        i_wb_valid = 1'b0;
        i_wb_en_a  = 1'b0;
        i_wb_en_b  = 1'b0;
        wr_pending = 1'b0;
endtask

// Puts one W line on the writeback bus for a single cycle
task automatic drive_write(input string line);
        logic [31:0]    mode;
        logic [31:0]    en_a;
        logic [31:0]    dst_a;
        logic [31:0]    data_a;
        logic [31:0]    en_b;
        logic [31:0]    dst_b;
        logic [31:0]    data_b;
        int             n;
        n = $sscanf(line, "W %h %h %h %h %h %h %h",
                    mode, en_a, dst_a, data_a, en_b, dst_b, data_b);
        if (n != 7)
        begin
                $display("ERROR: malformed write line in stimulus file: %s", line);
                run_errors++;
        end
        else
        begin
                // Back to back writes each get their own edge
                if (wr_pending)
                begin
                        @(posedge i_clk);
                        #1;
                end
                i_wb_valid  = 1'b1;
                i_wb_mode   = cpu_mode_t'(mode[4:0]);
                i_wb_en_a   = en_a[0];
                i_wb_dst_a  = log_addr_t'(dst_a[3:0]);
                i_wb_data_a = data_a;
                i_wb_en_b   = en_b[0];
                i_wb_dst_b  = log_addr_t'(dst_b[3:0]);
                i_wb_data_b = data_b;
                wr_pending  = 1'b1;
        end
endtask

// Issues one R line and holds it until the DUT takes it
// A write left on the bus shares the first cycle with this request
task automatic issue_read(input string line);
        logic [31:0]    mode;
        logic [31:0]    sa;
        logic [31:0]    sb;
        logic [31:0]    sc;
        logic [31:0]    sd;
        int             n;
        int             waited;
        logic           accepted;
        n = $sscanf(line, "R %h %h %h %h %h %h %h %h %h",
                    mode, sa, sb, sc, sd, exp_a, exp_b, exp_c, exp_d);
        if (n != 9)
        begin
                $display("ERROR: malformed read line in stimulus file: %s", line);
                run_errors++;
        end
        else
        begin
                i_rd_mode  = cpu_mode_t'(mode[4:0]);
                i_rd_src_a = log_addr_t'(sa[3:0]);
                i_rd_src_b = log_addr_t'(sb[3:0]);
                i_rd_src_c = log_addr_t'(sc[3:0]);
                i_rd_src_d = log_addr_t'(sd[3:0]);
                i_rd_valid = 1'b1;
                accepted   = 1'b0;
                waited     = 0;
                while (!accepted && waited < RD_TIMEOUT)
                begin
                        // Ready is settled by mid cycle and decides the coming edge
                        @(negedge i_clk);
                        accepted = o_rd_ready;
                        @(posedge i_clk);
                        #1;
                        retire_write();
                        waited++;
                end
                i_rd_valid = 1'b0;
                if (accepted)
                        reads_sent++;
                else
                begin
                        $display("ERROR: read request not accepted within %0d cycles",
                                 RD_TIMEOUT);
                        run_errors++;
                        aborted = 1'b1;
                end
        end
endtask

// --------------------------------------------------
// Main sequence
// --------------------------------------------------

initial
begin : main_seq
        int             fd;
        int             n;
        int             waited;
        string          line;

        i_reset     = 1'b1;
        i_wb_mode   = MODE_USR;
        i_wb_dst_a  = '0;
        i_wb_data_a = '0;
        i_wb_dst_b  = '0;
        i_wb_data_b = '0;
        i_rd_valid  = 1'b0;
        i_rd_mode   = MODE_USR;
        i_rd_src_a  = '0;
        i_rd_src_b  = '0;
        i_rd_src_c  = '0;
        i_rd_src_d  = '0;
        exp_a       = '0;
        exp_b       = '0;
        exp_c       = '0;
        exp_d       = '0;
        run_errors  = 0;
        reads_sent  = 0;
        aborted     = 1'b0;
        retire_write();

        fd = $fopen("reg_subsystem_stim.txt", "r");
        if (fd == 0)
        begin
                $display("ERROR: could not open reg_subsystem_stim.txt");
                run_errors++;
        end

        // Two rising edges in reset, then stimulus starts 1 ns after an edge
        repeat (2) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        // Lines that are not W or R are comments or blank
        while (fd != 0 && !aborted && !$feof(fd))
        begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 0 && line.getc(0) == "W")
                        drive_write(line);
                else if (n > 0 && line.getc(0) == "R")
                        issue_read(line);
        end
        if (fd != 0)
                $fclose(fd);

        if (wr_pending)
        begin
                @(posedge i_clk);
                #1;
                retire_write();
        end

        // Every accepted read has to come back before the run ends
        waited = 0;
        while (pending != 0 && waited < DRAIN_TIMEOUT)
        begin
                @(posedge i_clk);
                waited++;
        end
        if (pending != 0)
        begin
                $display("ERROR: %0d results still missing after %0d cycles",
                         pending, DRAIN_TIMEOUT);
                run_errors++;
        end
        else if (result_count != reads_sent)
        begin
                $display("ERROR: %0d reads accepted but %0d results seen",
                         reads_sent, result_count);
                run_errors++;
        end

        assert_errors = i_reg_subsystem.u_reg_subsystem_assert.fail_count;

        $display("Reads %0d, results %0d, compare errors %0d, %s %0d, other errors %0d",
                 reads_sent, result_count, check_errors, "assertion failures",
                 assert_errors, run_errors);
        if (check_errors == 0 && run_errors == 0 && assert_errors == 0)
                $display("SIMULATION PASSED");
        else
                $display("SIMULATION FAILED");
        $finish;
end

endmodule

// ==== zap_register_file.sv ====
`timescale 1ns/10ps

`include "regfile_config.svh"

module zap_register_file
        import regfile_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,

        // Shared write enable for both write ports
        input  logic            i_wen,
        input  phys_addr_t      i_wr_addr_a,
        input  phys_addr_t      i_wr_addr_b,
        input  reg_data_t       i_wr_data_a,
        input  reg_data_t       i_wr_data_b,

        // Four independent read ports
        input  phys_addr_t      i_rd_addr_a,
        input  phys_addr_t      i_rd_addr_b,
        input  phys_addr_t      i_rd_addr_c,
        input  phys_addr_t      i_rd_addr_d,
        output reg_data_t       o_rd_data_a,
        output reg_data_t       o_rd_data_b,
        output reg_data_t       o_rd_data_c,
        output reg_data_t       o_rd_data_d
);

// The whole register file lives in flip-flops
logic [`RF_NUM_REGS-1:0][`RF_DATA_W-1:0] mem;

// --------------------------------------------------
// Write side
// --------------------------------------------------

// Both ports commit on the same edge
// Port b is assigned last, so it wins when the two addresses collide
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                mem <= '0;
        end
        else if (i_wen)
        begin
                mem[i_wr_addr_a] <= i_wr_data_a;
                mem[i_wr_addr_b] <= i_wr_data_b;
        end
end

// --------------------------------------------------
// Read side
// --------------------------------------------------

// Reads see the array contents directly, with no pipeline stage
always_comb
begin
        o_rd_data_a = mem[i_rd_addr_a];
        o_rd_data_b = mem[i_rd_addr_b];
        o_rd_data_c = mem[i_rd_addr_c];
        o_rd_data_d = mem[i_rd_addr_d];
end

endmodule
